//--- dv/tbPipeFrontEnd.sv
`timescale 1ns/1ps

`include "pipe_params.svh"

module tbPipeFrontEnd;

    import PipePkg::*;

    localparam int MEM_WORDS   = 256;                       // Full pc[9:2] range
    localparam int END_PC      = (MEM_WORDS - 4) * 4;       // Last fetch the run waits for
    localparam int WATCHDOG_NS = (MEM_WORDS + 8) * 2 * 100; // Program plus reset times two

    typedef struct packed {
        logic [`PIPE_WIDTH-1:0] pc;
        ifIdPayload_t           ifId;
        idExPayload_t           idEx;
    } modelState_t;

    logic                   clk;
    logic                   rst;
    logic [`PIPE_WIDTH-1:0] instr;
    logic [`PIPE_WIDTH-1:0] pc;
    logic                   exMemRead;
    logic                   exRegWrite;
    regDst_t                exRegDst;
    regIdx_t                exRs;
    regIdx_t                exRt;
    regIdx_t                exRd;
    logic [`PIPE_WIDTH-1:0] exPcPlus4;
    logic                   stall;

    logic [`PIPE_WIDTH-1:0] imem [0:MEM_WORDS-1];          // Instruction memory model
    modelState_t            model;
    bit                     modelLive;                      // Set once reset is seen
    integer                 seed = 32'hf157_ff93;
    int                     errCount;
    int                     checkCount;

    opcode_t loadOps  [0:5] = '{OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU, OP_LWU};
    opcode_t storeOps [0:2] = '{OP_SW, OP_SB, OP_SH};
    opcode_t immOps   [0:7] = '{OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI,
                                OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU};

    PipeFrontEnd dut0 (
        .clk        (clk),
        .rst        (rst),
        .instr      (instr),
        .pc         (pc),
        .exMemRead  (exMemRead),
        .exRegWrite (exRegWrite),
        .exRegDst   (exRegDst),
        .exRs       (exRs),
        .exRt       (exRt),
        .exRd       (exRd),
        .exPcPlus4  (exPcPlus4),
        .stall      (stall)
    );

    always #50 clk = ~clk;                                  // 100 ns period

    // --------------------
    // Encoders
    // --------------------
    function automatic logic [31:0] iType(input opcode_t op, input regIdx_t rs,
                                          input regIdx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rType(input regIdx_t rs, input regIdx_t rt,
                                          input regIdx_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, 6'h20};         // ADD
    endfunction

    function automatic logic [31:0] jType(input opcode_t op, input int unsigned idx);
        return {op, 26'(idx)};                              // Word index in region 0
    endfunction

    // --------------------
    // Cycle model
    // --------------------
    function automatic idExPayload_t decodeExpected(input ifIdPayload_t f);
        idExPayload_t d;
        opcode_t      op;
        logic         rtype;
        op         = f.instr[31:26];
        rtype      = (op == OP_RTYPE) && (f.instr != `NOP_INSTR);
        d.memRead  = op inside {OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU, OP_LWU};
        d.regWrite = d.memRead || rtype || (op == OP_JAL)
                     || (op inside {OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI,
                                    OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU});
        d.regDst   = rtype ? DST_RD : ((op == OP_JAL) ? DST_RA : DST_RT);
        d.rs       = f.instr[25:21];
        d.rt       = f.instr[20:16];
        d.rd       = f.instr[15:11];
        d.pcPlus4  = f.pcPlus4;
        return d;
    endfunction

    function automatic logic loadUseDue(input modelState_t s);
        regIdx_t dst;
        dst = (s.idEx.regDst == DST_RD) ? s.idEx.rd : s.idEx.rt;   // Load destination
        return s.idEx.memRead && (s.idEx.regDst != DST_RA)
               && (dst == s.ifId.instr[25:21] || dst == s.ifId.instr[20:16]);
    endfunction

    function automatic modelState_t nextState(input modelState_t s,
                                              input logic [`PIPE_WIDTH-1:0] fetched);
        modelState_t n;
        logic        hold;
        logic        jump;
        hold = loadUseDue(s);
        jump = !hold && (s.ifId.instr[31:26] inside {OP_J, OP_JAL});  // Stall first
        n    = s;
        if (jump) begin
            n.pc   = {s.ifId.pcPlus4[31:28], s.ifId.instr[25:0], 2'b00};
            n.ifId = '0;                                    // Slot behind the jump
        end else if (!hold) begin
            n.pc           = s.pc + 4;
            n.ifId.pcPlus4 = s.pc + 4;
            n.ifId.instr   = fetched;
        end
        if (hold) begin
            n.idEx = '0;                                    // Bubble into EX
        end else begin
            n.idEx = decodeExpected(s.ifId);
        end
        return n;
    endfunction

    task automatic compareVal(input string name, input logic [`PIPE_WIDTH-1:0] exp,
                              input logic [`PIPE_WIDTH-1:0] got);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    // --------------------
    // Program image
    // --------------------
    task automatic buildProgram();
        int unsigned pick;
        int unsigned sub;
        regIdx_t     rs;
        regIdx_t     rt;
        regIdx_t     rd;
        imem[0]  = iType(OP_LW, 5'd2, 5'd1, 16'd0);         // r1 loaded
        imem[1]  = iType(OP_ADDI, 5'd1, 5'd3, 16'd5);       // r1 as rs stalls
        imem[2]  = iType(OP_LH, 5'd3, 5'd2, 16'd4);         // r2 loaded
        imem[3]  = rType(5'd4, 5'd2, 5'd5);                 // r2 as rt stalls
        imem[4]  = iType(OP_LBU, 5'd3, 5'd4, 16'd0);
        imem[5]  = iType(OP_ORI, 5'd5, 5'd6, 16'd1);        // Unrelated so no stall
        imem[6]  = rType(5'd1, 5'd2, 5'd7);
        imem[7]  = iType(OP_ADDI, 5'd7, 5'd8, 16'd1);       // ALU producer needs no stall
        imem[8]  = iType(OP_SW, 5'd7, 5'd8, 16'd0);
        imem[9]  = jType(OP_J, 12);
        imem[10] = rType(5'd1, 5'd1, 5'd9);                 // Flushed
        imem[11] = rType(5'd2, 5'd2, 5'd9);                 // Skipped
        imem[12] = jType(OP_JAL, 14);
        imem[13] = rType(5'd3, 5'd3, 5'd9);                 // Flushed
        for (int i = 14; i < MEM_WORDS; i++) begin
            pick = $unsigned($random(seed)) % 6;
            sub  = $unsigned($random(seed));
            rs   = 5'(1 + $unsigned($random(seed)) % 3);    // Small indices for frequent hazards
            rt   = 5'(1 + $unsigned($random(seed)) % 3);
            rd   = 5'(1 + $unsigned($random(seed)) % 3);
            case (pick)
                0: imem[i] = iType(loadOps[3'(sub % 6)], rs, rt, 16'(sub));
                1: imem[i] = iType(storeOps[2'(sub % 3)], rs, rt, 16'(sub));
                2: imem[i] = iType(immOps[3'(sub % 8)], rs, rt, 16'(sub));
                3: imem[i] = rType(rs, rt, rd);
                default: begin
                    if (i < MEM_WORDS - 8) begin            // Forward targets so pc reaches the end
                        imem[i] = jType((pick == 4) ? OP_J : OP_JAL,
                                        i + 1 + sub % (MEM_WORDS - 5 - i));
                    end else begin
                        imem[i] = rType(rs, rt, rd);
                    end
                end
            endcase
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    always @(negedge clk) begin
        instr <= imem[pc[9:2]];                             // Combinational imem read
    end

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        instr = `NOP_INSTR;
        buildProgram();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        compareVal("pc", `RESET_PC, pc);                    // State right after reset
        compareVal("exMemRead", '0, 32'(exMemRead));
        compareVal("exRegWrite", '0, 32'(exRegWrite));
        compareVal("exRegDst", '0, 32'(exRegDst));
        compareVal("exPcPlus4", '0, exPcPlus4);
        compareVal("stall", '0, 32'(stall));
        wait (pc == END_PC);
        repeat (3) @(posedge clk);                          // Drain to EX
        @(negedge clk);
        $display("Checks done: %0d errors in %0d compares", errCount, checkCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Model steps on each edge and outputs are compared just after it
    initial begin
        model     = '0;
        modelLive = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                model     = '0;
                model.pc  = `RESET_PC;
                modelLive = 1'b1;
            end else if (modelLive) begin
                model = nextState(model, imem[model.pc[9:2]]);
            end
            #1;
            if (modelLive) begin
                compareVal("pc", model.pc, pc);
                compareVal("exMemRead", 32'(model.idEx.memRead), 32'(exMemRead));
                compareVal("exRegWrite", 32'(model.idEx.regWrite), 32'(exRegWrite));
                compareVal("exRegDst", 32'(model.idEx.regDst), 32'(exRegDst));
                compareVal("exRs", 32'(model.idEx.rs), 32'(exRs));
                compareVal("exRt", 32'(model.idEx.rt), 32'(exRt));
                compareVal("exRd", 32'(model.idEx.rd), 32'(exRd));
                compareVal("exPcPlus4", model.idEx.pcPlus4, exPcPlus4);
                compareVal("stall", 32'(loadUseDue(model)), 32'(stall));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: pc never reached the end of the program");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- include/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// --------------------
// Datapath geometry
// --------------------
`define PIPE_WIDTH 32                   // Data and address width

// --------------------
// Fixed encodings
// --------------------
`define RESET_PC  32'h0000_0000         // First fetch address
`define NOP_INSTR 32'h0000_0000         // sll $0,$0,0 used as a flush

`endif

//--- run.sh
#!/bin/sh
# Build and run the front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
    --top-module tbPipeFrontEnd -o simv \
    && ./obj_dir/simv | tee sim.log \
    || echo "Build or simulation error"
grep -q "Simulation finished: PASS" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- source/Hazard.sv
`timescale 1ns/1ps

module Hazard (
    input  PipePkg::opcode_t opCode,        // Opcode sitting in IF/ID
    input  PipePkg::regIdx_t regRsIfId,     // Sources of the instruction in ID
    input  PipePkg::regIdx_t regRtIfId,
    input  PipePkg::regIdx_t regRtIdEx,     // Candidate destinations in EX
    input  PipePkg::regIdx_t regRdIdEx,
    input  logic             memReadIdEx,   // EX holds a load
    input  PipePkg::regDst_t regDstIdEx,
    output logic             PCWrite,
    output logic             IFIDWrite,
    output logic             ControlStall,  // Bubble into ID/EX
    output logic             BranchFlush    // Jump redirect allowed
);

    import PipePkg::*;

    logic loadUse;                          // Load result needed next cycle
    logic isJumpOp;                         // J or JAL in ID

    // --------------------
    // Condition detection
    // --------------------
    always_comb begin
        loadUse = 1'b0;
        if (memReadIdEx) begin
            case (regDstIdEx)
                DST_RT:  loadUse = (regRtIdEx == regRsIfId) || (regRtIdEx == regRtIfId);
                DST_RD:  loadUse = (regRdIdEx == regRsIfId) || (regRdIdEx == regRtIfId);
                default: loadUse = 1'b0;    // A load never targets r31
            endcase
        end
    end

    assign isJumpOp = (opCode == OP_J) || (opCode == OP_JAL);

    // --------------------
    // Priority resolution
    // --------------------
    always_comb begin
        if (loadUse) begin                  // Stall wins over a jump
            PCWrite      = 1'b0;
            IFIDWrite    = 1'b0;
            ControlStall = 1'b1;
            BranchFlush  = 1'b0;            // Keep the jump parked in ID
        end else if (isJumpOp) begin
            PCWrite      = 1'b1;            // Target load
            IFIDWrite    = 1'b0;            // Slot behind is dropped
            ControlStall = 1'b0;
            BranchFlush  = 1'b1;
        end else begin
            PCWrite      = 1'b1;            // Free flow
            IFIDWrite    = 1'b1;
            ControlStall = 1'b0;
            BranchFlush  = 1'b1;
        end
    end

endmodule

//--- source/InstrDecode.sv
`timescale 1ns/1ps

`include "pipe_params.svh"

module InstrDecode (
    input  logic [`PIPE_WIDTH-1:0] instr,       // From IF/ID
    input  logic [`PIPE_WIDTH-1:0] pcPlus4,     // From IF/ID
    output PipePkg::opcode_t       opCode,
    output PipePkg::regIdx_t       rs,
    output PipePkg::regIdx_t       rt,
    output PipePkg::regIdx_t       rd,
    output logic                   memRead,
    output logic                   regWrite,
    output PipePkg::regDst_t       regDst,
    output logic                   isJump,
    output logic [`PIPE_WIDTH-1:0] jumpTarget
);

    import PipePkg::*;

    logic isNop;                                // Flushed slot
    logic isLoad;
    logic isImmAlu;
    logic isRtype;                              // Real R-type, NOP excluded
    logic isJal;

    // --------------------
    // Field split
    // --------------------
    assign opCode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    assign isNop   = (instr == `NOP_INSTR);
    assign isRtype = (opCode == OP_RTYPE) && !isNop;
    assign isJal   = (opCode == OP_JAL);

    // --------------------
    // Opcode classes
    // --------------------
    always_comb begin
        isLoad   = 1'b0;
        isImmAlu = 1'b0;
        case (opCode)
            OP_LW, OP_LB, OP_LH, OP_LBU, OP_LHU, OP_LWU:
                isLoad = 1'b1;
            OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU:
                isImmAlu = 1'b1;
            OP_SW, OP_SB, OP_SH: ;              // Stores read only
            default: ;                          // R-type, jumps, unknown
        endcase
    end

    // --------------------
    // Control fields
    // --------------------
    assign memRead  = isLoad;
    assign regWrite = isLoad || isImmAlu || isRtype || isJal;

    always_comb begin
        if (isRtype) begin
            regDst = DST_RD;
        end else if (isJal) begin
            regDst = DST_RA;                    // Link into r31
        end else begin
            regDst = DST_RT;                    // Also the NOP value
        end
    end

    // Pseudo-direct target with region bits from the jump's own pc+4
    assign isJump     = (opCode == OP_J) || isJal;
    assign jumpTarget = {pcPlus4[`PIPE_WIDTH-1:`PIPE_WIDTH-4], instr[25:0], 2'b00};

endmodule

//--- source/PipeFrontEnd.sv
`timescale 1ns/1ps

`include "pipe_params.svh"

module PipeFrontEnd (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`PIPE_WIDTH-1:0] instr,       // Imem data for pc, same cycle
    output logic [`PIPE_WIDTH-1:0] pc,
    output logic                   exMemRead,
    output logic                   exRegWrite,
    output PipePkg::regDst_t       exRegDst,
    output PipePkg::regIdx_t       exRs,
    output PipePkg::regIdx_t       exRt,
    output PipePkg::regIdx_t       exRd,
    output logic [`PIPE_WIDTH-1:0] exPcPlus4,
    output logic                   stall        // ControlStall for the observer
);

    import PipePkg::*;

    // --------------------
    // Interconnect
    // --------------------
    logic [`PIPE_WIDTH-1:0] pcPlus4;
    logic [`PIPE_WIDTH-1:0] jumpTarget;
    ifIdPayload_t           ifIdIn;
    ifIdPayload_t           ifIdOut;
    idExPayload_t           idExIn;
    idExPayload_t           idExOut;
    opcode_t                opCode;
    logic                   isJump;
    logic                   jumpTaken;          // Jump cleared to redirect
    logic                   pcWrite;
    logic                   ifIdWrite;
    logic                   controlStall;
    logic                   branchFlush;

    assign jumpTaken = isJump && branchFlush;   // Suppressed under a stall

    // --------------------
    // IF stage
    // --------------------
    ProgramCounter pc0 (
        .clk        (clk),
        .rst        (rst),
        .PCWrite    (pcWrite),
        .loadTarget (jumpTaken),
        .jumpTarget (jumpTarget),
        .pc         (pc),
        .pcPlus4    (pcPlus4)
    );

    assign ifIdIn.pcPlus4 = pcPlus4;
    assign ifIdIn.instr   = instr;

    PipeReg #(.payload_t(ifIdPayload_t)) ifId0 (
        .clk     (clk),
        .rst     (rst),
        .writeEn (ifIdWrite),
        .bubble  (jumpTaken),                   // Kill the slot behind the jump
        .din     (ifIdIn),
        .dout    (ifIdOut)
    );

    // --------------------
    // ID stage
    // --------------------
    InstrDecode dec0 (
        .instr      (ifIdOut.instr),
        .pcPlus4    (ifIdOut.pcPlus4),
        .opCode     (opCode),
        .rs         (idExIn.rs),
        .rt         (idExIn.rt),
        .rd         (idExIn.rd),
        .memRead    (idExIn.memRead),
        .regWrite   (idExIn.regWrite),
        .regDst     (idExIn.regDst),
        .isJump     (isJump),
        .jumpTarget (jumpTarget)
    );

    assign idExIn.pcPlus4 = ifIdOut.pcPlus4;

    Hazard haz0 (
        .opCode       (opCode),
        .regRsIfId    (idExIn.rs),
        .regRtIfId    (idExIn.rt),
        .regRtIdEx    (idExOut.rt),
        .regRdIdEx    (idExOut.rd),
        .memReadIdEx  (idExOut.memRead),
        .regDstIdEx   (idExOut.regDst),
        .PCWrite      (pcWrite),
        .IFIDWrite    (ifIdWrite),
        .ControlStall (controlStall),
        .BranchFlush  (branchFlush)
    );

    PipeReg #(.payload_t(idExPayload_t)) idEx0 (
        .clk     (clk),
        .rst     (rst),
        .writeEn (1'b1),                        // EX never holds
        .bubble  (controlStall),
        .din     (idExIn),
        .dout    (idExOut)
    );

    // --------------------
    // EX view
    // --------------------
    assign exMemRead  = idExOut.memRead;
    assign exRegWrite = idExOut.regWrite;
    assign exRegDst   = idExOut.regDst;
    assign exRs       = idExOut.rs;
    assign exRt       = idExOut.rt;
    assign exRd       = idExOut.rd;
    assign exPcPlus4  = idExOut.pcPlus4;
    assign stall      = controlStall;

    // The bubble pushes the load out of EX, so a load-use stall lasts one cycle
    stallOneCycle : assert property (
        @(posedge clk) disable iff (rst)
        controlStall |=> !controlStall
    ) else $error("PipeFrontEnd: load-use stall held past one cycle");

endmodule

//--- source/PipePkg.sv
`include "pipe_params.svh"

package PipePkg;

    // --------------------
    // Instruction fields
    // --------------------
    typedef logic [4:0] regIdx_t;       // GPR index
    typedef logic [5:0] opcode_t;       // Major opcode, instr[31:26]

    // Major opcodes
    localparam opcode_t OP_RTYPE = 6'b000000;  // Funct decides
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_SLTIU = 6'b001011;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_LB    = 6'b100000;
    localparam opcode_t OP_LH    = 6'b100001;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_LBU   = 6'b100100;
    localparam opcode_t OP_LHU   = 6'b100101;
    localparam opcode_t OP_LWU   = 6'b100111;
    localparam opcode_t OP_SB    = 6'b101000;
    localparam opcode_t OP_SH    = 6'b101001;
    localparam opcode_t OP_SW    = 6'b101011;

    // Write-back register select
    typedef enum logic [1:0] {
        DST_RT = 2'b00,                 // I-type
        DST_RD = 2'b01,                 // R-type
        DST_RA = 2'b10                  // JAL, register 31
    } regDst_t;

    // --------------------
    // Stage payloads
    // --------------------
    typedef struct packed {
        logic [`PIPE_WIDTH-1:0] pcPlus4;
        logic [`PIPE_WIDTH-1:0] instr;
    } ifIdPayload_t;

    typedef struct packed {
        logic                   memRead;
        logic                   regWrite;
        regDst_t                regDst;
        regIdx_t                rs;
        regIdx_t                rt;
        regIdx_t                rd;
        logic [`PIPE_WIDTH-1:0] pcPlus4;  // Link value for JAL
    } idExPayload_t;

endpackage

//--- source/PipeReg.sv
`timescale 1ns/1ps

module PipeReg #(
    parameter type payload_t = logic        // Stage bundle
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     writeEn,               // Low holds the stage
    input  logic     bubble,                // Squash to NOP over writeEn
    input  payload_t din,
    output payload_t dout
);

    // --------------------
    // Stage register
    // --------------------
    // All-zero payload decodes to a NOP with every control bit inactive
    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            dout <= '0;
        end else if (writeEn) begin
            dout <= din;                    // Normal advance
        end
    end

endmodule

//--- source/ProgramCounter.sv
`timescale 1ns/1ps

`include "pipe_params.svh"

module ProgramCounter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   PCWrite,     // Low during load-use stall
    input  logic                   loadTarget,  // Jump resolved in ID
    input  logic [`PIPE_WIDTH-1:0] jumpTarget,
    output logic [`PIPE_WIDTH-1:0] pc,
    output logic [`PIPE_WIDTH-1:0] pcPlus4
);

    logic [`PIPE_WIDTH-1:0] pcNext;

    // --------------------
    // Next address
    // --------------------
    assign pcPlus4 = pc + `PIPE_WIDTH'(4);      // Sequential fetch
    assign pcNext  = loadTarget ? jumpTarget : pcPlus4;

    // --------------------
    // PC register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (PCWrite) begin
            pc <= pcNext;
        end                                     // Else hold for the stall
    end

    // Jump targets carry two zero bits, so the PC never leaves a word boundary
    pcAligned : assert property (
        @(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00
    ) else $error("ProgramCounter: misaligned pc %h", pc);

endmodule

//--- verilog.f
+incdir+include
source/PipePkg.sv
source/Hazard.sv
source/ProgramCounter.sv
source/PipeReg.sv
source/InstrDecode.sv
source/PipeFrontEnd.sv
dv/tbPipeFrontEnd.sv
